// ==== src/image_xform_pkg.sv ====
/*
 * image transform package
 * sizes of the 16x16 pixel image and its word layout, fill constants,
 * and the opcode, controller state and pixel operation encodings
 */

package image_xform_pkg;

   ////////////////////////////////////////
   // image geometry
   ////////////////////////////////////////

   // one pixel is a byte, four pixels per memory word
   localparam int PIX_W        = 8;
   localparam int WORD_W       = 32;
   localparam int PIX_PER_WORD = WORD_W / PIX_W;

   // 16 pixels per side, 4 words per image row
   localparam int IMG_DIM      = 16;
   localparam int NUM_WORDS    = (IMG_DIM * IMG_DIM) / PIX_PER_WORD;
   localparam int ADDR_W       = $clog2(NUM_WORDS);

   // extra top bit selects the rotate write-back phase
   localparam int CNT_W        = ADDR_W + 1;

   // one full scratchpad row, 16 pixels
   localparam int ROW_W        = IMG_DIM * PIX_W;

   ////////////////////////////////////////
   // constants
   ////////////////////////////////////////

   localparam logic [PIX_W-1:0]  PIX_STEP   = 8'd16;
   localparam logic [WORD_W-1:0] BLACK_WORD = '0;
   localparam logic [WORD_W-1:0] WHITE_WORD = '1;
   localparam logic [WORD_W-1:0] GREY_WORD  = {PIX_PER_WORD{8'hf0}};

   // status bits that carry information, rest read as zero
   localparam int STAT_W = 6;

   // host opcodes, codes 12 to 15 behave as nop
   typedef enum logic [3:0] {
      OP_NOP      = 4'd0,
      OP_LOADMEM  = 4'd1,
      OP_READMEM  = 4'd2,
      OP_READSTAT = 4'd3,
      OP_ALLBLACK = 4'd4,
      OP_ALLWHITE = 4'd5,
      OP_ALLGREY  = 4'd6,
      OP_DARKEN   = 4'd7,
      OP_LIGHTEN  = 4'd8,
      OP_INVERT   = 4'd9,
      OP_ROTCW    = 4'd10,
      OP_ROTCCW   = 4'd11
   } opcode_e;

   typedef enum logic [1:0] {ST_IDLE = 2'd0, ST_BUSY = 2'd1, ST_DONE = 2'd2} xform_state_e;

   typedef enum logic [1:0] {PX_PASS, PX_DARK, PX_LITE, PX_INVT} pixel_op_e;

endpackage

// ==== src/pixel_word_op.sv ====
/*
 * pixel word alu
 * darken and lighten by a fixed step with saturation, or invert,
 * on all four pixels of a word independently
 */

module pixel_word_op (
   input  image_xform_pkg::pixel_op_e           px_op,
   input  logic [image_xform_pkg::WORD_W-1:0]   data_in,
   output logic [image_xform_pkg::WORD_W-1:0]   data_out
);

   logic [image_xform_pkg::PIX_W-1:0] pix;
   // one extra bit for carry and borrow
   logic [image_xform_pkg::PIX_W:0]   sum;
   logic [image_xform_pkg::PIX_W:0]   diff;

   always_comb
   begin
      data_out = data_in;
      pix      = '0;
      sum      = '0;
      diff     = '0;
      for (int p = 0; p < image_xform_pkg::PIX_PER_WORD; p++)
      begin
         pix  = data_in[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W];
         sum  = {1'b0, pix} + {1'b0, image_xform_pkg::PIX_STEP};
         diff = {1'b0, pix} - {1'b0, image_xform_pkg::PIX_STEP};
         case (px_op)
            // borrow out means the pixel was below the step, clamp to black
            image_xform_pkg::PX_DARK:
               data_out[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W] =
                  diff[image_xform_pkg::PIX_W] ? '0 : diff[image_xform_pkg::PIX_W-1:0];
            // carry out clamps to white
            image_xform_pkg::PX_LITE:
               data_out[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W] =
                  sum[image_xform_pkg::PIX_W] ? '1 : sum[image_xform_pkg::PIX_W-1:0];
            image_xform_pkg::PX_INVT:
               data_out[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W] = ~pix;
            default:
               data_out[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W] = pix;
         endcase
      end
   end

endmodule

// ==== src/xform_ctrl.sv ====
/*
 * image transform controller
 * idle/busy/done FSM, sweep counter sized by the op class,
 * done interrupt with host acknowledge, and the status word
 */

module xform_ctrl (
   input  logic                                 clk,
   input  logic                                 rst_b,
   input  image_xform_pkg::opcode_e             op,
   input  logic                                 int_ack,
   output logic                                 busy,
   output logic [image_xform_pkg::CNT_W-1:0]    cnt,
   output logic                                 done_int,
   output logic [image_xform_pkg::WORD_W-1:0]   stat_word
);

   image_xform_pkg::xform_state_e state;
   image_xform_pkg::xform_state_e next_state;

   logic one_cyc_op;
   logic sweep_op;
   logic rotate_op;
   logic valid_op;
   logic last_cyc;

   ////////////////////////////////////////
   // op classes
   ////////////////////////////////////////

   // single access ops, busy for one cycle
   assign one_cyc_op = (op == image_xform_pkg::OP_LOADMEM) ||
                       (op == image_xform_pkg::OP_READMEM);
   // fills and pixel ops sweep all 64 words
   assign sweep_op   = op inside {image_xform_pkg::OP_ALLBLACK, image_xform_pkg::OP_ALLWHITE,
                                  image_xform_pkg::OP_ALLGREY, image_xform_pkg::OP_DARKEN,
                                  image_xform_pkg::OP_LIGHTEN, image_xform_pkg::OP_INVERT};
   // rotates load then write back, 128 cycles
   assign rotate_op  = op inside {image_xform_pkg::OP_ROTCW, image_xform_pkg::OP_ROTCCW};
   assign valid_op   = one_cyc_op || sweep_op || rotate_op;

   // final busy cycle of the current op
   // an op that changed away mid sweep ends at once
   always_comb
   begin
      if (sweep_op)
         last_cyc = (cnt[image_xform_pkg::ADDR_W-1:0] == '1);
      else if (rotate_op)
         last_cyc = (cnt == '1);
      else
         last_cyc = 1'b1;
   end

   ////////////////////////////////////////
   // state machine
   ////////////////////////////////////////

   always_comb
   begin
      next_state = state;
      case (state)
         image_xform_pkg::ST_IDLE:
            // nop, readstat and unused codes stay idle
            if (valid_op)
               next_state = image_xform_pkg::ST_BUSY;
         image_xform_pkg::ST_BUSY:
            if (last_cyc)
               next_state = image_xform_pkg::ST_DONE;
         image_xform_pkg::ST_DONE:
            if (int_ack)
               next_state = image_xform_pkg::ST_IDLE;
         default:
            next_state = image_xform_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         state <= image_xform_pkg::ST_IDLE;
      else
         state <= next_state;
   end

   assign busy = (state == image_xform_pkg::ST_BUSY);

   // sweep counter, zero outside busy, steps every busy cycle but the last
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         cnt <= '0;
      else if (!busy || last_cyc)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   // done interrupt, set leaving busy, cleared by the acknowledge in done
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         done_int <= 1'b0;
      else if (busy && last_cyc)
         done_int <= 1'b1;
      else if ((state == image_xform_pkg::ST_DONE) && int_ack)
         done_int <= 1'b0;
   end

   // status: done, rotate, 64 cycle op, write-back phase, state
   assign stat_word = {{(image_xform_pkg::WORD_W - image_xform_pkg::STAT_W){1'b0}},
                       done_int, rotate_op, sweep_op,
                       rotate_op && cnt[image_xform_pkg::CNT_W-1], state};

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // interrupt only comes out of a finished busy cycle
   a_done_from_busy : assert property (@(posedge clk) disable iff (!rst_b)
      $rose(done_int) |-> ($past(state) == image_xform_pkg::ST_BUSY) &&
                          (state == image_xform_pkg::ST_DONE));

   // count climbs strictly across consecutive busy cycles
   a_cnt_no_wrap : assert property (@(posedge clk) disable iff (!rst_b)
      ($past(busy) && busy) |-> (cnt > $past(cnt)));

endmodule

// ==== src/image_mem.sv ====
/*
 * image memory
 * 64 words of four pixels, row 0 at the bottom, column 0 in the low byte.
 * selects the read address and write source per op, maps op to the
 * pixel alu code, and holds the registered host read data
 */

module image_mem (
   input  logic                                 clk,
   input  logic                                 rst_b,
   input  image_xform_pkg::opcode_e             op,
   input  logic                                 busy,
   input  logic [image_xform_pkg::CNT_W-1:0]    cnt,
   input  logic [image_xform_pkg::ADDR_W-1:0]   addr,
   input  logic [image_xform_pkg::WORD_W-1:0]   wdata,
   input  logic [image_xform_pkg::WORD_W-1:0]   px_word,
   input  logic [image_xform_pkg::WORD_W-1:0]   scratch_word,
   input  logic [image_xform_pkg::WORD_W-1:0]   stat_word,
   output logic [image_xform_pkg::WORD_W-1:0]   mem_word,
   output image_xform_pkg::pixel_op_e           px_op,
   output logic [image_xform_pkg::WORD_W-1:0]   rdata
);

   logic [image_xform_pkg::WORD_W-1:0] mem [image_xform_pkg::NUM_WORDS];

   logic [image_xform_pkg::ADDR_W-1:0] rd_addr;
   logic                               wr_en;
   logic [image_xform_pkg::ADDR_W-1:0] wr_addr;
   logic [image_xform_pkg::WORD_W-1:0] wr_data;

   // host address for a word read, sweep position otherwise
   assign rd_addr  = (op == image_xform_pkg::OP_READMEM) ? addr :
                     cnt[image_xform_pkg::ADDR_W-1:0];
   assign mem_word = mem[rd_addr];

   // pixel alu code
   always_comb
   begin
      case (op)
         image_xform_pkg::OP_DARKEN:  px_op = image_xform_pkg::PX_DARK;
         image_xform_pkg::OP_LIGHTEN: px_op = image_xform_pkg::PX_LITE;
         image_xform_pkg::OP_INVERT:  px_op = image_xform_pkg::PX_INVT;
         default:                     px_op = image_xform_pkg::PX_PASS;
      endcase
   end

   ////////////////////////////////////////
   // write source
   ////////////////////////////////////////

   always_comb
   begin
      wr_en   = 1'b0;
      wr_addr = cnt[image_xform_pkg::ADDR_W-1:0];
      wr_data = px_word;
      case (op)
         image_xform_pkg::OP_LOADMEM:
         begin
            wr_en   = busy;
            wr_addr = addr;
            wr_data = wdata;
         end
         image_xform_pkg::OP_ALLBLACK:
         begin
            wr_en   = busy;
            wr_data = image_xform_pkg::BLACK_WORD;
         end
         image_xform_pkg::OP_ALLWHITE:
         begin
            wr_en   = busy;
            wr_data = image_xform_pkg::WHITE_WORD;
         end
         image_xform_pkg::OP_ALLGREY:
         begin
            wr_en   = busy;
            wr_data = image_xform_pkg::GREY_WORD;
         end
         // alu result of the word just read
         image_xform_pkg::OP_DARKEN, image_xform_pkg::OP_LIGHTEN, image_xform_pkg::OP_INVERT:
            wr_en = busy;
         // rotated rows only in the second half of the sweep
         image_xform_pkg::OP_ROTCW, image_xform_pkg::OP_ROTCCW:
         begin
            wr_en   = busy && cnt[image_xform_pkg::CNT_W-1];
            wr_data = scratch_word;
         end
         default:
            wr_en = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         for (int i = 0; i < image_xform_pkg::NUM_WORDS; i++)
            mem[i] <= '0;
      else if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // host read data, word at the end of the readmem cycle or live status
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         rdata <= '0;
      else if (busy && (op == image_xform_pkg::OP_READMEM))
         rdata <= mem_word;
      else if (op == image_xform_pkg::OP_READSTAT)
         rdata <= stat_word;
   end

   // outside busy the word at a held read address never changes
   a_no_write_idle : assert property (@(posedge clk) disable iff (!rst_b)
      !busy ##1 (rd_addr == $past(rd_addr)) |-> $stable(mem_word));

endmodule

// ==== src/rotate_scratch.sv ====
/*
 * rotate scratchpad
 * 16 rows of 16 pixels. the load phase scatters each old word's four
 * pixels to their rotated row and column, the write-back phase hands
 * the new image back one word at a time in plain word order
 */

module rotate_scratch (
   input  logic                                 clk,
   input  logic                                 rst_b,
   input  image_xform_pkg::opcode_e             op,
   input  logic                                 busy,
   input  logic [image_xform_pkg::CNT_W-1:0]    cnt,
   input  logic [image_xform_pkg::WORD_W-1:0]   mem_word,
   output logic [image_xform_pkg::WORD_W-1:0]   scratch_word
);

   // new row index, new column in bits 8c+7:8c
   logic [image_xform_pkg::ROW_W-1:0] scratch [image_xform_pkg::IMG_DIM];

   logic rot_cw;
   logic load_en;
   logic wb_phase;

   // position of the old word being loaded
   logic [$clog2(image_xform_pkg::IMG_DIM)-1:0] old_row;
   logic [$clog2(image_xform_pkg::IMG_DIM)-1:0] old_col [image_xform_pkg::PIX_PER_WORD];

   // rotated target of each of the four pixels
   logic [$clog2(image_xform_pkg::IMG_DIM)-1:0] dst_row [image_xform_pkg::PIX_PER_WORD];
   logic [$clog2(image_xform_pkg::IMG_DIM)-1:0] dst_col [image_xform_pkg::PIX_PER_WORD];

   logic [image_xform_pkg::ROW_W-1:0] scratch_row;

   assign rot_cw   = (op == image_xform_pkg::OP_ROTCW);
   assign wb_phase = cnt[image_xform_pkg::CNT_W-1];
   assign load_en  = busy && !wb_phase &&
                     (rot_cw || (op == image_xform_pkg::OP_ROTCCW));

   // 4 words per image row
   assign old_row = cnt[image_xform_pkg::ADDR_W-1:2];

   ////////////////////////////////////////
   // rotation mapping
   ////////////////////////////////////////

   // cw   old (R,C) lands at new (15-C, R)
   // ccw  old (R,C) lands at new (C, 15-R)
   // 15-x is the bitwise complement on a 4 bit index
   always_comb
   begin
      for (int p = 0; p < image_xform_pkg::PIX_PER_WORD; p++)
      begin
         old_col[p] = {cnt[1:0], 2'(p)};
         dst_row[p] = rot_cw ? ~old_col[p] : old_col[p];
         dst_col[p] = rot_cw ? old_row : ~old_row;
      end
   end

   // each load cycle fills one column position in four different rows
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         for (int r = 0; r < image_xform_pkg::IMG_DIM; r++)
            scratch[r] <= '0;
      else if (load_en)
         for (int p = 0; p < image_xform_pkg::PIX_PER_WORD; p++)
            scratch[dst_row[p]][dst_col[p]*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W]
               <= mem_word[p*image_xform_pkg::PIX_W +: image_xform_pkg::PIX_W];
   end

   ////////////////////////////////////////
   // write-back read
   ////////////////////////////////////////

   // new word cnt[5:0] is row cnt[5:2], segment cnt[1:0]
   assign scratch_row  = scratch[cnt[image_xform_pkg::ADDR_W-1:2]];
   assign scratch_word = scratch_row[cnt[1:0]*image_xform_pkg::WORD_W +: image_xform_pkg::WORD_W];

   // row being drained holds still while write-back walks its segments
   a_no_load_in_wb : assert property (@(posedge clk) disable iff (!rst_b)
      (busy && wb_phase && (cnt[1:0] != 2'b11)) |=> $stable(scratch_row));

endmodule

// ==== src/image_xform.sv ====
/*
 * image transform block, top level
 * 16x16 byte image held as 64 words, with word load and read, status read,
 * whole image fills, per pixel darken, lighten and invert, and rotation
 * by 90 degrees in either direction through a row scratchpad
 */

module image_xform (
   input  logic                                 clk,
   input  logic                                 rst_b,
   input  logic [image_xform_pkg::ADDR_W-1:0]   addr,
   input  logic [image_xform_pkg::WORD_W-1:0]   wdata,
   input  image_xform_pkg::opcode_e             op,
   input  logic                                 int_ack,
   output logic [image_xform_pkg::WORD_W-1:0]   rdata,
   output logic                                 done_int
);

   // shared sweep control from the controller
   logic                                busy;
   logic [image_xform_pkg::CNT_W-1:0]   cnt;
   logic [image_xform_pkg::WORD_W-1:0]  stat_word;

   // datapath words
   logic [image_xform_pkg::WORD_W-1:0]  mem_word;
   logic [image_xform_pkg::WORD_W-1:0]  px_word;
   logic [image_xform_pkg::WORD_W-1:0]  scratch_word;
   image_xform_pkg::pixel_op_e          px_op;

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////

   xform_ctrl i_ctrl (
      .clk       (clk),
      .rst_b     (rst_b),
      .op        (op),
      .int_ack   (int_ack),
      .busy      (busy),
      .cnt       (cnt),
      .done_int  (done_int),
      .stat_word (stat_word)
   );

   ////////////////////////////////////////
   // datapath
   ////////////////////////////////////////

   image_mem i_mem (
      .clk          (clk),
      .rst_b        (rst_b),
      .op           (op),
      .busy         (busy),
      .cnt          (cnt),
      .addr         (addr),
      .wdata        (wdata),
      .px_word      (px_word),
      .scratch_word (scratch_word),
      .stat_word    (stat_word),
      .mem_word     (mem_word),
      .px_op        (px_op),
      .rdata        (rdata)
   );

   // four pixel alu on the word being swept
   pixel_word_op i_px_op (
      .px_op    (px_op),
      .data_in  (mem_word),
      .data_out (px_word)
   );

   rotate_scratch i_rot (
      .clk          (clk),
      .rst_b        (rst_b),
      .op           (op),
      .busy         (busy),
      .cnt          (cnt),
      .mem_word     (mem_word),
      .scratch_word (scratch_word)
   );

endmodule

// ==== test/tb_image_xform.sv ====
/*
 * image transform testbench
 * drives the host opcode, address and data, keeps a 64 word model of the
 * image, and checks rdata and the done interrupt with concurrent assertions
 */

module tb_image_xform;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 10;
   localparam logic [15:0] LFSR_SEED = 16'd4;

   // cycle budget of each op covers its issue, ack and check edges
   localparam int OP_OVH   = 4;
   localparam int WORD_OP  = 1 + OP_OVH;
   localparam int IMAGE_IO = 64 * WORD_OP;
   localparam int SWEEP_OP = 64 + OP_OVH;
   localparam int ROT_OP   = 128 + OP_OVH;
   localparam int BUDGET   = 20 + 2 * IMAGE_IO + 3 * (SWEEP_OP + IMAGE_IO) +
                             3 * (2 * IMAGE_IO + SWEEP_OP) + 4 * IMAGE_IO + 6 * ROT_OP + 30;
   localparam int MARGIN   = 200;

   logic                      clk;
   logic                      rst_b;
   logic [5:0]                addr;
   logic [31:0]               wdata;
   image_xform_pkg::opcode_e  op;
   logic                      int_ack;
   logic [31:0]               rdata;
   logic                      done_int;

   // reference image and check controls
   logic [31:0] model [64];
   logic [31:0] rd_exp;
   logic        rd_check;
   logic        issue;
   int          busy_len;
   logic [15:0] lfsr;
   string       test_name;
   int          errors;
   int          n_pass;
   int          n_fail;

   image_xform i_dut (
      .clk      (clk),
      .rst_b    (rst_b),
      .addr     (addr),
      .wdata    (wdata),
      .op       (op),
      .int_ack  (int_ack),
      .rdata    (rdata),
      .done_int (done_int)
   );

   always
   begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_rdata : assert property (@(posedge clk) disable iff (!rst_b) rd_check |-> rdata == rd_exp)
      else
      begin
         errors++;
         $display("Mismatch %s: expected %08h actual %08h", test_name, $sampled(rd_exp),
                  $sampled(rdata));
      end

   // done rises on the edge ending the last busy cycle and never before
   a_done_1 : assert property (@(posedge clk) disable iff (!rst_b)
      (issue && busy_len == 1) |-> ##1 !done_int ##1 done_int)
      else
      begin
         errors++;
         $display("%s: done_int not raised one cycle after busy began", test_name);
      end
   a_done_64 : assert property (@(posedge clk) disable iff (!rst_b)
      (issue && busy_len == 64) |-> ##64 !done_int ##1 done_int)
      else
      begin
         errors++;
         $display("%s: done_int not raised 64 cycles after busy began", test_name);
      end
   a_done_128 : assert property (@(posedge clk) disable iff (!rst_b)
      (issue && busy_len == 128) |-> ##128 !done_int ##1 done_int)
      else
      begin
         errors++;
         $display("%s: done_int not raised 128 cycles after busy began", test_name);
      end

   a_done_hold : assert property (@(posedge clk) disable iff (!rst_b)
      (done_int && !int_ack) |=> done_int)
      else
      begin
         errors++;
         $display("%s: done_int dropped without an acknowledge", test_name);
      end
   a_done_clear : assert property (@(posedge clk) disable iff (!rst_b)
      (done_int && int_ack) |=> !done_int)
      else
      begin
         errors++;
         $display("%s: done_int stayed high after the acknowledge", test_name);
      end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++)
         w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   // saturating step of 16 or complement on each byte
   function automatic logic [31:0] pixel_ref(input image_xform_pkg::opcode_e o,
                                             input logic [31:0] w);
      logic [31:0] res;
      logic [7:0]  p;
      res = w;
      for (int i = 0; i < 4; i++)
      begin
         p = w[8*i +: 8];
         if (o == image_xform_pkg::OP_DARKEN)
            res[8*i +: 8] = (p < 8'd16) ? 8'h00 : p - 8'd16;
         else if (o == image_xform_pkg::OP_LIGHTEN)
            res[8*i +: 8] = (p > 8'd239) ? 8'hff : p + 8'd16;
         else
            res[8*i +: 8] = ~p;
      end
      return res;
   endfunction

   // pixel (r, c) sits in word r*4 + c/4 at byte c%4
   function automatic logic [7:0] get_pix(input int r, input int c);
      return model[r*4 + c/4][8*(c%4) +: 8];
   endfunction

   task automatic model_rotate(input logic cw);
      logic [31:0] nxt [64];
      for (int r = 0; r < 16; r++)
         for (int c = 0; c < 16; c++)
            nxt[r*4 + c/4][8*(c%4) +: 8] = cw ? get_pix(c, 15 - r) : get_pix(15 - c, r);
      model = nxt;
   endtask

   ////////////////////////////////////////
   // op sequencing
   ////////////////////////////////////////

   task automatic start_op(input image_xform_pkg::opcode_e o, input int len);
      op       = o;
      busy_len = len;
      issue    = 1'b1;
      @(posedge clk);
      #1;
      issue = 1'b0;
   endtask

   task automatic wait_done(input int len);
      int n;
      n = 0;
      while (!done_int && n < len + 4)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!done_int)
      begin
         errors++;
         $display("%s: done_int did not rise within %0d cycles", test_name, len + 4);
      end
   endtask

   task automatic ack_done();
      int_ack = 1'b1;
      op      = image_xform_pkg::OP_NOP;
      @(posedge clk);
      #1;
      int_ack = 1'b0;
   endtask

   task automatic run_op(input image_xform_pkg::opcode_e o, input int len);
      start_op(o, len);
      wait_done(len);
      ack_done();
   endtask

   // arm a_rdata for the next edge
   task automatic expect_rdata(input logic [31:0] exp);
      rd_exp   = exp;
      rd_check = 1'b1;
      @(posedge clk);
      #1;
      rd_check = 1'b0;
   endtask

   task automatic load_word(input int a, input logic [31:0] w);
      addr     = a;
      wdata    = w;
      model[a] = w;
      run_op(image_xform_pkg::OP_LOADMEM, 1);
   endtask

   // rdata checked on the ack edge one cycle after the busy cycle
   task automatic check_image();
      for (int a = 0; a < 64; a++)
      begin
         addr = a;
         start_op(image_xform_pkg::OP_READMEM, 1);
         wait_done(1);
         rd_exp   = model[a];
         rd_check = 1'b1;
         ack_done();
         rd_check = 1'b0;
      end
   endtask

   task automatic check_status(input logic [31:0] exp);
      op = image_xform_pkg::OP_READSTAT;
      @(posedge clk);
      #1;
      expect_rdata(exp);
      op = image_xform_pkg::OP_NOP;
   endtask

   // random image with saturation edge pixels in the first two words
   task automatic load_image();
      load_word(0, 32'hffeff0f1);
      load_word(1, 32'h000f1011);
      for (int a = 2; a < 64; a++)
         load_word(a, random_word());
   endtask

   task automatic fill_pass(input image_xform_pkg::opcode_e o, input logic [31:0] w);
      run_op(o, 64);
      for (int a = 0; a < 64; a++)
         model[a] = w;
      check_image();
   endtask

   task automatic pixel_pass(input image_xform_pkg::opcode_e o);
      load_image();
      run_op(o, 64);
      for (int a = 0; a < 64; a++)
         model[a] = pixel_ref(o, model[a]);
      check_image();
   endtask

   task automatic rotate_pass(input logic cw);
      if (cw)
         run_op(image_xform_pkg::OP_ROTCW, 128);
      else
         run_op(image_xform_pkg::OP_ROTCCW, 128);
      model_rotate(cw);
   endtask

   task automatic end_test(input int errs_before);
      if (errors == errs_before)
      begin
         n_pass++;
         $display("test %s passed", test_name);
      end
      else
      begin
         n_fail++;
         $display("test %s failed with %0d errors", test_name, errors - errs_before);
      end
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   initial
   begin
      int errs;
      clk = 1'b0;
      rst_b = 1'b0;
      addr = '0;
      wdata = '0;
      op = image_xform_pkg::OP_NOP;
      int_ack = 1'b0;
      rd_exp = '0;
      rd_check = 1'b0;
      issue = 1'b0;
      busy_len = 0;
      lfsr = LFSR_SEED;
      errors = 0;
      n_pass = 0;
      n_fail = 0;
      test_name = "reset";
      repeat (5) @(posedge clk);
      #1;
      rst_b = 1'b1;

      errs = errors;
      assert (done_int == 1'b0)
         else
         begin
            errors++;
            $display("reset: done_int high after reset");
         end
      expect_rdata(32'h0);
      check_status(32'h0);
      end_test(errs);

      test_name = "load_read";
      errs = errors;
      for (int a = 0; a < 64; a++)
         load_word(a, random_word());
      check_image();
      end_test(errs);

      test_name = "fill";
      errs = errors;
      fill_pass(image_xform_pkg::OP_ALLWHITE, 32'hffffffff);
      fill_pass(image_xform_pkg::OP_ALLGREY, 32'hf0f0f0f0);
      fill_pass(image_xform_pkg::OP_ALLBLACK, 32'h00000000);
      end_test(errs);

      test_name = "pixel";
      errs = errors;
      pixel_pass(image_xform_pkg::OP_DARKEN);
      pixel_pass(image_xform_pkg::OP_LIGHTEN);
      pixel_pass(image_xform_pkg::OP_INVERT);
      end_test(errs);

      // one cw turn undone by a ccw turn and then four cw turns in a row
      test_name = "rotate";
      errs = errors;
      load_image();
      rotate_pass(1'b1);
      check_image();
      rotate_pass(1'b0);
      check_image();
      repeat (4) rotate_pass(1'b1);
      check_image();
      end_test(errs);

      test_name = "done_ack";
      errs = errors;
      addr = 6'd5;
      start_op(image_xform_pkg::OP_READMEM, 1);
      wait_done(1);
      expect_rdata(model[5]);
      // a_done_hold watches these unacknowledged cycles
      repeat (4) @(posedge clk);
      #1;
      // done state with the done flag
      check_status(32'h00000022);
      ack_done();
      check_status(32'h0);
      end_test(errs);

      $display("tests passed %0d failed %0d errors %0d", n_pass, n_fail, errors);
      if (errors == 0 && n_fail == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // watchdog over the summed test budgets
   initial
   begin
      #((BUDGET + MARGIN) * CLK_PERIOD);
      $display("run timed out after %0d cycles in test %s", BUDGET + MARGIN, test_name);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== vlog.f ====
src/image_xform_pkg.sv
src/pixel_word_op.sv
src/xform_ctrl.sv
src/image_mem.sv
src/rotate_scratch.sv
src/image_xform.sv
test/tb_image_xform.sv
